// File: filelist.f
+incdir+src
src/cpu_pkg.sv
src/program_counter.sv
src/control_block.sv
src/alu.sv
src/register.sv
src/instruction_register.sv
src/input_mar_register.sv
src/dff_ram.sv
src/datapath.sv
src/cpu_top.sv
dv/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build the CPU testbench with Verilator, run it into a log, then look for the pass line
LOG=sim.log

verilator --binary --timing -j 0 --top-module cpu_tb -f filelist.f -o cpu_sim \
    && ./obj_dir/cpu_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -q '^\*\* PASS \*\*$' "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: dv/cpu_tb.sv
// Testbench for the accumulator CPU
// Program loader over the RAM load port, reference ISA model
// Output monitor, directed tests and random programs

`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb;

    import cpu_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MAX_INSNS      = 200;  // Model step limit per program
    localparam int MAX_OUTS       = 20;   // Outputs compared when a program never halts

    logic                   clk;
    logic                   rst;
    logic                   prog_we;
    logic [`CPU_ADDR_W-1:0] prog_addr;
    logic [`CPU_DATA_W-1:0] prog_data;
    logic [`CPU_DATA_W-1:0] out_data;
    logic                   out_valid;
    logic                   halted;

    logic [`CPU_DATA_W-1:0] prog [`CPU_RAM_WORDS];  // Image loaded for the next run
    logic [`CPU_DATA_W-1:0] exp_q [$];              // Outputs still expected
    logic [`CPU_DATA_W-1:0] last_out;
    string                  test_name;
    bit                     ignore_extra;  // Set for programs that never halt
    int                     seen;          // Outputs observed in this run
    int                     checks;
    int                     errors;

    cpu_top dut (
        .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .out_data(out_data), .out_valid(out_valid), .halted(halted)
    );

    always #4 clk = ~clk;  // 8 ns period

    // Walks the program with the ISA rules, fills exp_q, returns whether HLT is reached
    function automatic bit isa_model();
        logic [`CPU_DATA_W-1:0] mem [`CPU_RAM_WORDS];
        logic [7:0]             a;
        logic [7:0]             operand;
        logic [8:0]             sum;
        logic [3:0]             pc;
        logic [3:0]             arg;
        opcode_e                op;
        bit                     carry;
        bit                     zero;
        exp_q.delete();
        for (int k = 0; k < `CPU_RAM_WORDS; k++) begin
            mem[k[3:0]] = prog[k[3:0]];  // STA may rewrite the program
        end
        a     = 8'h00;
        pc    = 4'h0;
        carry = 1'b0;
        zero  = 1'b0;
        for (int n = 0; n < MAX_INSNS; n++) begin
            op      = opcode_e'(mem[pc][7:4]);
            arg     = mem[pc][3:0];
            pc      = pc + 4'd1;  // Wraps at 16
            operand = mem[arg];
            case (op)
                OP_LDA: a = operand;
                OP_ADD: begin
                    sum   = {1'b0, a} + {1'b0, operand};
                    a     = sum[7:0];
                    carry = sum[8];
                    zero  = (a == 8'h00);
                end
                OP_SUB: begin
                    carry = (a >= operand);  // No borrow
                    a     = a - operand;
                    zero  = (a == 8'h00);
                end
                OP_STA: mem[arg] = a;
                OP_LDI: a = {4'h0, arg};
                OP_JMP: pc = arg;
                OP_JC:  if (carry) pc = arg;
                OP_JZ:  if (zero) pc = arg;
                OP_OUT: exp_q.push_back(a);
                OP_HLT: return 1'b1;
                default: ;  // Unused opcodes do nothing
            endcase
        end
        return 1'b0;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    // Unused bytes become no-op opcode 8 tagged with their address
    task automatic clear_program();
        for (int k = 0; k < `CPU_RAM_WORDS; k++) begin
            prog[k[3:0]] = {4'h8, k[3:0]};
        end
    endtask

    // Expects rst already high, writes every byte, then releases rst
    task automatic load_program();
        for (int k = 0; k < `CPU_RAM_WORDS; k++) begin
            @(posedge clk);
            #1;
            prog_we   = 1'b1;
            prog_addr = k[3:0];
            prog_data = prog[k[3:0]];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        rst     = 1'b0;  // First T1 follows
    endtask

    task automatic wait_for_halt();
        int cyc;
        cyc = 0;
        while (!halted && cyc < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cyc++;
        end
        checks++;
        if (!halted) begin
            $display("%s: no halt within %0d cycles", test_name, TIMEOUT_CYCLES);
            errors++;
        end
    endtask

    // Model found no HLT in MAX_INSNS instructions, so the CPU runs that long
    // without halting and gives every expected output on the way
    task automatic watch_without_halt(input int count);
        int cyc;
        cyc = 0;
        while (!halted && cyc < MAX_INSNS * `CPU_T_STATES) begin
            @(negedge clk);
            cyc++;
        end
        #1;
        checks++;
        if (halted) begin
            $display("%s: CPU halted although the program never reaches HLT", test_name);
            errors++;
        end
        checks++;
        if (seen < count) begin
            $display("%s: only %0d of %0d outputs within %0d instructions",
                     test_name, seen, count, MAX_INSNS);
            errors++;
        end
    endtask

    // Reset, reload, run to halt or through the model's instruction budget
    task automatic run_program(input string name);
        bit halts;
        int n_exp;
        @(posedge clk);
        #1;
        rst     = 1'b1;  // Monitor is idle from here
        prog_we = 1'b0;
        test_name = name;
        halts = isa_model();
        if (!halts) begin
            while (exp_q.size() > MAX_OUTS) begin
                void'(exp_q.pop_back());
            end
        end
        n_exp        = exp_q.size();
        ignore_extra = !halts;
        seen         = 0;
        last_out     = 'x;  // No output yet in this run
        load_program();
        if (halts) begin
            wait_for_halt();
            checks++;
            if (exp_q.size() != 0) begin
                $display("%s: halted with %0d expected outputs missing", name, exp_q.size());
                errors++;
            end
        end else begin
            watch_without_halt(n_exp);
        end
    endtask

    // Output monitor, samples on the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            seen++;
            last_out = out_data;
            if (exp_q.size() == 0) begin
                if (!ignore_extra) begin
                    $display("%s: output %02h arrived with none expected", test_name, out_data);
                    errors++;
                end
            end else begin
                checks++;
                if (out_data !== exp_q[0]) begin
                    $display("FAIL %s: expected %02h, actual %02h", test_name, exp_q[0], out_data);
                    errors++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    // Overall limit on simulated time
    initial begin
        #2_000_000;
        $display("Simulation time limit reached before the tests finished");
        $display("checks=%0d errors=%0d", checks, errors + 1);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] sum8;
        logic [3:0] imm;
        void'($urandom(32'h67be));
        clk = 1'b0;
        rst = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        last_out = '0;
        test_name = "reset";
        ignore_extra = 1'b0;
        seen = 0;
        checks = 0;
        errors = 0;
        repeat (8) @(posedge clk);

        // LDA, ADD, OUT, HLT on random bytes
        for (int k = 0; k < 3; k++) begin
            x = rand_byte();
            y = rand_byte();
            sum8 = x + y;
            clear_program();
            prog[0] = 8'h0E;
            prog[1] = 8'h1F;
            prog[2] = 8'hE0;
            prog[3] = 8'hF0;
            prog[14] = x;
            prog[15] = y;
            run_program("load_add_out");
            checks++;
            if (last_out !== sum8) begin
                $display("FAIL load_add_out: expected %02h, actual %02h", sum8, last_out);
                errors++;
            end
        end

        // SUB then JZ, taken path outputs zero then 0F
        for (int k = 0; k < 2; k++) begin
            x = rand_byte();
            y = (k == 0) ? x : rand_byte();
            if (k == 1 && y == x) y = x ^ 8'h01;
            clear_program();
            prog[0] = 8'h0E;
            prog[1] = 8'h2F;
            prog[2] = 8'h75;  // JZ 5
            prog[3] = 8'hE0;
            prog[4] = 8'hF0;
            prog[5] = 8'hE0;
            prog[6] = 8'h4F;
            prog[7] = 8'hE0;
            prog[8] = 8'hF0;
            prog[14] = x;
            prog[15] = y;
            run_program((k == 0) ? "sub_jz_equal" : "sub_jz_unequal");
        end

        // ADD then JC over one of two OUTs, first case forces a carry
        for (int k = 0; k < 4; k++) begin
            x = (k == 0) ? 8'hFF : rand_byte();
            y = (k == 0) ? 8'h01 : rand_byte();
            clear_program();
            prog[0] = 8'h0E;
            prog[1] = 8'h1F;
            prog[2] = 8'h64;  // JC 4
            prog[3] = 8'hE0;
            prog[4] = 8'hE0;
            prog[5] = 8'hF0;
            prog[14] = x;
            prog[15] = y;
            run_program("add_jc");
        end

        // LDI, STA, overwrite A, LDA back
        for (int k = 0; k < 3; k++) begin
            x = rand_byte();
            imm = x[3:0];
            clear_program();
            prog[0] = {4'h4, imm};
            prog[1] = 8'h3E;
            prog[2] = 8'h40;  // A cleared before reload
            prog[3] = 8'h0E;
            prog[4] = 8'hE0;
            prog[5] = 8'hF0;
            run_program("store_reload");
            checks++;
            if (last_out !== {4'h0, imm}) begin
                $display("FAIL store_reload: expected %02h, actual %02h", {4'h0, imm}, last_out);
                errors++;
            end
        end

        // Count by a random step until the adder carries
        for (int k = 0; k < 2; k++) begin
            x = rand_byte();
            y = 8'd8 + {2'b00, x[5:0]};  // Step 8 to 71 keeps the loop short
            clear_program();
            prog[0] = {4'h4, x[7:4]};
            prog[1] = 8'hE0;
            prog[2] = 8'h1F;
            prog[3] = 8'h65;  // Exit on carry
            prog[4] = 8'h51;
            prog[5] = 8'hF0;
            prog[15] = y;
            run_program("count_loop");
        end

        for (int k = 0; k < 5; k++) begin
            for (int j = 0; j < `CPU_RAM_WORDS; j++) begin
                prog[j[3:0]] = rand_byte();
            end
            run_program($sformatf("random_prog_%0d", k));
        end

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: src/cpu_top.sv
// Accumulator CPU top level
// Control, PC, IR, memory path and datapath around one shared bus

`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prog_we,    // RAM load port, used only during rst
    input  logic [`CPU_ADDR_W-1:0] prog_addr,
    input  logic [`CPU_DATA_W-1:0] prog_data,
    output logic [`CPU_DATA_W-1:0] out_data,
    output logic                   out_valid,
    output logic                   halted
);

    import cpu_pkg::*;

    ctrl_word_t             ctrl;
    opcode_e                opcode;
    alu_flags_t             flags;
    logic [`CPU_DATA_W-1:0] bus;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] ir_bus;     // Operand, zero-extended
    logic [`CPU_ADDR_W-1:0] ram_addr;
    logic [`CPU_DATA_W-1:0] ram_wdata;
    logic                   ram_we;
    logic [`CPU_DATA_W-1:0] ram_rdata;

    control_block cb (
        .clk(clk), .rst(rst), .opcode(opcode), .flags(flags),
        .ctrl(ctrl), .halted(halted)
    );

    program_counter pc_inst (.clk(clk), .rst(rst), .ctrl(ctrl), .bus(bus), .pc(pc));

    instruction_register ir (
        .clk(clk), .rst(rst), .ctrl(ctrl), .bus(bus), .opcode(opcode), .ir_bus(ir_bus)
    );

    input_mar_register mar (
        .clk(clk), .rst(rst), .ctrl(ctrl), .bus(bus),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we)
    );

    dff_ram ram (.clk(clk), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata));

    datapath dp (
        .clk(clk), .rst(rst), .ctrl(ctrl), .pc(pc), .ram_bus(ram_rdata), .ir_bus(ir_bus),
        .bus(bus), .flags(flags), .out_data(out_data), .out_valid(out_valid)
    );

endmodule

// File: src/datapath.sv
// Datapath
// Bus source select, accumulator, B and output registers, ALU
// Output valid pulse one cycle after the output register loads

`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_pkg::ctrl_word_t    ctrl,
    input  logic [`CPU_ADDR_W-1:0] pc,
    input  logic [`CPU_DATA_W-1:0] ram_bus,
    input  logic [`CPU_DATA_W-1:0] ir_bus,
    output logic [`CPU_DATA_W-1:0] bus,
    output cpu_pkg::alu_flags_t    flags,
    output logic [`CPU_DATA_W-1:0] out_data,
    output logic                   out_valid
);

    logic [`CPU_DATA_W-1:0] a_q;         // Accumulator
    logic [`CPU_DATA_W-1:0] b_q;
    logic [`CPU_DATA_W-1:0] alu_result;

    // Bus mux, control drives at most one enable per cycle
    always_comb begin
        bus = '0;  // Nothing enabled reads as zero
        if (ctrl.pc_out)       bus = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, pc};
        else if (ctrl.ram_out) bus = ram_bus;
        else if (ctrl.ir_out)  bus = ir_bus;
        else if (ctrl.a_out)   bus = a_q;
        else if (ctrl.alu_out) bus = alu_result;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_q       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (ctrl.a_load) a_q <= bus;
            out_valid <= ctrl.o_load;  // Lines up with the new out_data
        end
    end

    register b_register (
        .clk (clk),
        .rst (rst),
        .load(ctrl.b_load),
        .d   (bus),
        .q   (b_q)
    );

    register output_register (
        .clk (clk),
        .rst (rst),
        .load(ctrl.o_load),
        .d   (bus),
        .q   (out_data)
    );

    alu alu_inst (
        .clk     (clk),
        .rst     (rst),
        .a       (a_q),
        .b       (b_q),
        .sub     (ctrl.alu_sub),
        .flags_en(ctrl.alu_out),  // Flags follow ADD and SUB only
        .result  (alu_result),
        .flags   (flags)
    );

endmodule

// File: src/dff_ram.sv
// Flip-flop RAM, one byte per address
// Synchronous write, combinational read

`timescale 1ns/1ps
`include "cpu_params.svh"

module dff_ram (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`CPU_ADDR_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0] wdata,
    output logic [`CPU_DATA_W-1:0] rdata
);

    // Program and data share the array
    logic [`CPU_DATA_W-1:0] mem [`CPU_RAM_WORDS];

    // Contents survive rst so a loaded program is kept
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Read data valid in the same cycle as the address
    assign rdata = mem[addr];

endmodule

// File: src/input_mar_register.sv
// Memory address and write data registers in front of the RAM
// Load port takes over the RAM while rst is high

`timescale 1ns/1ps
`include "cpu_params.svh"

module input_mar_register (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_pkg::ctrl_word_t    ctrl,
    input  logic [`CPU_DATA_W-1:0] bus,
    input  logic                   prog_we,
    input  logic [`CPU_ADDR_W-1:0] prog_addr,
    input  logic [`CPU_DATA_W-1:0] prog_data,
    output logic [`CPU_ADDR_W-1:0] ram_addr,
    output logic [`CPU_DATA_W-1:0] ram_wdata,
    output logic                   ram_we
);

    logic [`CPU_ADDR_W-1:0] mar_q;  // Low nibble of the bus
    logic [`CPU_DATA_W-1:0] mdr_q;

    always_ff @(posedge clk) begin
        if (ctrl.mar_load) mar_q <= bus[`CPU_ADDR_W-1:0];
        if (ctrl.mdr_load) mdr_q <= bus;
    end

    // Program loading path, only open during rst
    assign ram_addr  = rst ? prog_addr : mar_q;
    assign ram_wdata = rst ? prog_data : mdr_q;
    assign ram_we    = rst ? prog_we : ctrl.ram_write;

endmodule

// File: src/instruction_register.sv
// Instruction register
// Opcode nibble to control, operand nibble to the bus

`timescale 1ns/1ps
`include "cpu_params.svh"

module instruction_register (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_pkg::ctrl_word_t    ctrl,
    input  logic [`CPU_DATA_W-1:0] bus,
    output cpu_pkg::opcode_e       opcode,
    output logic [`CPU_DATA_W-1:0] ir_bus
);

    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] ir_q;

    always_ff @(posedge clk) begin
        if (rst) ir_q <= '0;  // Decodes as LDA, harmless at T6
        else if (ctrl.ir_load) ir_q <= bus;
    end

    // Unused codes pass through and decode to no action
    assign opcode = opcode_e'(ir_q[`CPU_DATA_W-1:`CPU_ADDR_W]);
    assign ir_bus = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, ir_q[`CPU_ADDR_W-1:0]};

endmodule

// File: src/register.sv
// Bus-loaded register with synchronous clear
// Serves as the B register and the output register

`timescale 1ns/1ps
`include "cpu_params.svh"

module register #(
    parameter int WIDTH = `CPU_DATA_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    always_ff @(posedge clk) begin
        if (rst) q <= '0;
        else if (load) q <= d;  // Holds otherwise
    end

endmodule

// File: src/alu.sv
// Adder/subtractor on A and B
// Carry and zero flags registered when the result is taken

`timescale 1ns/1ps
`include "cpu_params.svh"

module alu (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  logic                   sub,
    input  logic                   flags_en,
    output logic [`CPU_DATA_W-1:0] result,
    output cpu_pkg::alu_flags_t    flags
);

    logic [`CPU_DATA_W-1:0] b_eff;  // B or its complement
    logic [`CPU_DATA_W:0]   sum;    // Extra bit is the carry out

    // Two's complement subtract, carry in is the sub bit
    assign b_eff  = sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{`CPU_DATA_W{1'b0}}, sub};
    assign result = sum[`CPU_DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (flags_en) begin
            flags.carry <= sum[`CPU_DATA_W];  // For SUB, set when a >= b
            flags.zero  <= (result == '0);
        end
    end

endmodule

// File: src/control_block.sv
// Control block
// One-hot T-state ring counter, halt latch
// Opcode and T-state to control word decoder

`timescale 1ns/1ps
`include "cpu_params.svh"

module control_block (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::opcode_e    opcode,
    input  cpu_pkg::alu_flags_t flags,
    output cpu_pkg::ctrl_word_t ctrl,
    output logic                halted
);

    import cpu_pkg::*;

    // Bit positions in the ring, T6 decodes to an idle word
    localparam int T1 = 0;
    localparam int T2 = 1;
    localparam int T3 = 2;
    localparam int T4 = 3;
    localparam int T5 = 4;

    logic [`CPU_T_STATES-1:0] t_state;  // One hot
    logic                     halt_now;  // T3 of HLT
    logic                     jump_ok;   // Jump taken for JMP, JC, JZ

    assign halt_now = t_state[T3] && (opcode == OP_HLT);

    assign jump_ok = (opcode == OP_JMP) ||
                     ((opcode == OP_JC) && flags.carry) ||
                     ((opcode == OP_JZ) && flags.zero);

    // Reset parks the ring at T6, so the first edge after rst starts T1
    always_ff @(posedge clk) begin
        if (rst) begin
            t_state <= {1'b1, {(`CPU_T_STATES-1){1'b0}}};
            halted  <= 1'b0;
        end else begin
            if (!(halted || halt_now)) begin
                t_state <= {t_state[`CPU_T_STATES-2:0], t_state[`CPU_T_STATES-1]};
            end
            if (halt_now) halted <= 1'b1;  // Held until the next rst
        end
    end

    always_comb begin
        ctrl = '0;
        // Fetch, same for every opcode
        if (t_state[T1]) begin
            ctrl.pc_out   = 1'b1;
            ctrl.mar_load = 1'b1;
        end
        if (t_state[T2]) begin
            ctrl.ram_out = 1'b1;
            ctrl.ir_load = 1'b1;
            ctrl.pc_inc  = 1'b1;
        end
        // Execute
        if (t_state[T3]) begin
            case (opcode)
                OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                    ctrl.ir_out   = 1'b1;  // Operand address into MAR
                    ctrl.mar_load = 1'b1;
                end
                OP_LDI: begin
                    ctrl.ir_out = 1'b1;
                    ctrl.a_load = 1'b1;
                end
                OP_JMP, OP_JC, OP_JZ: begin
                    ctrl.ir_out  = jump_ok;
                    ctrl.pc_load = jump_ok;  // Not taken, PC already points past
                end
                OP_OUT: begin
                    ctrl.a_out  = 1'b1;
                    ctrl.o_load = 1'b1;
                end
                default: ;  // HLT handled by the latch, unused opcodes idle
            endcase
        end
        if (t_state[T4]) begin
            case (opcode)
                OP_LDA: begin
                    ctrl.ram_out = 1'b1;
                    ctrl.a_load  = 1'b1;
                end
                OP_ADD, OP_SUB: begin
                    ctrl.ram_out = 1'b1;
                    ctrl.b_load  = 1'b1;
                end
                // A and the operand cannot share the bus, data follows a cycle later
                OP_STA: begin
                    ctrl.a_out    = 1'b1;
                    ctrl.mdr_load = 1'b1;
                end
                default: ;
            endcase
        end
        if (t_state[T5]) begin
            case (opcode)
                OP_ADD, OP_SUB: begin
                    ctrl.alu_out = 1'b1;  // Also latches the flags
                    ctrl.alu_sub = (opcode == OP_SUB);
                    ctrl.a_load  = 1'b1;
                end
                OP_STA: ctrl.ram_write = 1'b1;
                default: ;
            endcase
        end
        if (rst) ctrl = '0;  // Idle word while the program loads
    end

endmodule

// File: src/program_counter.sv
// Program counter
// Counts up on pc_inc, loads the jump target from the bus on pc_load

`timescale 1ns/1ps
`include "cpu_params.svh"

module program_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_pkg::ctrl_word_t    ctrl,
    input  logic [`CPU_DATA_W-1:0] bus,
    output logic [`CPU_ADDR_W-1:0] pc
);

    logic [`CPU_ADDR_W-1:0] pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (ctrl.pc_load) begin
            pc_q <= bus[`CPU_ADDR_W-1:0];  // Jump wins over count
        end else if (ctrl.pc_inc) begin
            // Wraps from 15 back to 0
            pc_q <= pc_q + {{(`CPU_ADDR_W-1){1'b0}}, 1'b1};
        end
    end

    assign pc = pc_q;  // Zero-extended onto the bus by the datapath

endmodule

// File: src/cpu_pkg.sv
// Shared CPU types
// Opcode enum, control word struct, ALU flags struct

package cpu_pkg;

    // Upper nibble of the instruction byte
    typedef enum logic [3:0] {
        OP_LDA = 4'h0,  // A <- mem[addr]
        OP_ADD = 4'h1,  // A <- A + mem[addr]
        OP_SUB = 4'h2,  // A <- A - mem[addr]
        OP_STA = 4'h3,  // mem[addr] <- A
        OP_LDI = 4'h4,  // A <- imm, zero-extended
        OP_JMP = 4'h5,
        OP_JC  = 4'h6,  // Jump on carry
        OP_JZ  = 4'h7,  // Jump on zero
        OP_OUT = 4'hE,  // Output register <- A
        OP_HLT = 4'hF
    } opcode_e;

    // One control word per cycle, all enables active high
    typedef struct packed {
        logic pc_inc;     // Count up
        logic pc_out;     // PC onto the bus
        logic pc_load;    // Jump target from the bus
        logic mar_load;
        logic mdr_load;   // RAM write data from the bus
        logic ram_out;
        logic ram_write;
        logic ir_load;
        logic ir_out;     // Operand nibble onto the bus
        logic a_load;
        logic a_out;
        logic alu_sub;    // Subtract instead of add
        logic alu_out;    // ALU result onto the bus, also updates flags
        logic b_load;
        logic o_load;
    } ctrl_word_t;

    typedef struct packed {
        logic carry;  // Adder carry out, no borrow for SUB
        logic zero;
    } alu_flags_t;

endpackage

// File: src/cpu_params.svh
// Shared sizing macros for the accumulator CPU
// Bus width, address width, RAM depth, cycles per instruction

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus and register width
`define CPU_DATA_W 8

`define CPU_ADDR_W 4      // PC and MAR width
`define CPU_RAM_WORDS 16  // One word per address

// Fixed instruction length, T1 to T6
`define CPU_T_STATES 6

`endif
